//--- include/alu_defines.svh
// ----------------------------------------------------------------------
// Widths, opcodes, error codes and CCR bit positions for the ALU
// Include wherever a width or an encoding is needed
// ----------------------------------------------------------------------
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Field widths
`define ALU_WIDTH      32  // Data path and instruction word
`define ALU_FMT_WIDTH  2   // Instruction format select
`define ALU_OPA_WIDTH  17  // Format a opcode
`define ALU_OPC_WIDTH  6   // Format b and c opcode
`define ALU_IMM_WIDTH  26  // Format c immediate

// Format a opcodes
`define OPC_ADD   17'h00040
`define OPC_SUB   17'h00100
`define OPC_AND   17'h00200
`define OPC_OR    17'h00240
`define OPC_NEG   17'h00280  // Two's complement of ra
`define OPC_XOR   17'h002C0
`define OPC_COMP  17'h00300  // One's complement of ra
`define OPC_LSR   17'h00400
`define OPC_ASR   17'h00440
`define OPC_LSL   17'h004C0
`define OPC_ROR   17'h00640  // Rotate through C
`define OPC_ROL   17'h00680  // Rotate through C
`define OPC_MOVE  17'h00800

// Six-bit opcodes, formats b and c
`define OPC_LDI      6'h22  // Sign-extended immediate
`define OPC_LDU      6'h23  // Zero-extended immediate
`define OPC_NOP_LOW  6'h3F  // Low six bits, any format but 3

// Result codes driven onto rz on a bad word
`define ERR_FMT_A   32'hFFFFFFFF
`define ERR_FMT_B   32'hFFFFFFFE
`define ERR_FMT_C   32'hFFFFFFFC
`define ERR_FORMAT  32'hF0F0F0F0  // Format 3

// CCR bit positions, bits above IFNR read zero
`define CCR_C     0
`define CCR_N     1
`define CCR_V     2
`define CCR_Z     3
`define CCR_INR   4
`define CCR_IFNR  5

`endif

//--- hdl/aluPkg.sv
// ----------------------------------------------------------------------
// Shared ALU types: decoded operation, instruction format and the
// three views of the instruction word
// ----------------------------------------------------------------------
`include "alu_defines.svh"

package aluPkg;

	// Decoded operation, decoder to datapath
	typedef enum logic [4:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_NEG,
		OP_XOR,
		OP_COMP,
		OP_LSR,
		OP_ASR,
		OP_LSL,
		OP_ROR,
		OP_ROL,
		OP_MOVE,
		OP_LDI,
		OP_LDU,
		OP_NOP,
		OP_ERR_INR,   // Opcode not recognized
		OP_ERR_IFNR   // Format 3
	} aluOpE;

	// Encoding of the instructionFormat input
	typedef enum logic [`ALU_FMT_WIDTH-1:0] {
		FMT_A   = 2'd0,
		FMT_B   = 2'd1,
		FMT_C   = 2'd2,
		FMT_BAD = 2'd3
	} instrFormatE;

	// One instruction word, read per format
	typedef union packed {
		struct packed {
			logic [4:0]                  rsrc1;
			logic [4:0]                  rsrc2;
			logic [4:0]                  rdst;
			logic [`ALU_OPA_WIDTH-1:0]   opcode;
		} formatA;
		struct packed {
			logic [4:0]                  rsrc1;
			logic [4:0]                  rsrc2;
			logic [15:0]                 immediate;  // No format b user yet
			logic [`ALU_OPC_WIDTH-1:0]   opcode;
		} formatB;
		struct packed {
			logic [`ALU_IMM_WIDTH-1:0]   immediate;
			logic [`ALU_OPC_WIDTH-1:0]   opcode;
		} formatC;
	} instrWordU;

endpackage

//--- hdl/aluResultIf.sv
// ----------------------------------------------------------------------
// Combinational result and flag strobes, datapath to the output register
// Datapath drives the source side, register reads the sink side
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

interface aluResultIf;
	logic [`ALU_WIDTH-1:0] result;  // Next rz
	logic carryOut;       // New C, valid with writeCarry
	logic overflowOut;    // New V, valid with writeOverflow
	logic writeCarry;
	logic writeOverflow;
	logic isNop;          // Hold rz and ccr
	logic setInr;
	logic setIfnr;

	modport source (
		output result, carryOut, overflowOut, writeCarry, writeOverflow,
		output isNop, setInr, setIfnr
	);

	modport sink (
		input result, carryOut, overflowOut, writeCarry, writeOverflow,
		input isNop, setInr, setIfnr
	);
endinterface

//--- hdl/instructionDecoder.sv
// ----------------------------------------------------------------------
// Instruction decoder, purely combinational
// Maps format and opcode to an operation, the extended format c
// immediate and the error code for that format
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

module instructionDecoder (
	input  aluPkg::instrWordU         instruction,
	input  aluPkg::instrFormatE       instructionFormat,
	output aluPkg::aluOpE             op,
	output logic [`ALU_WIDTH-1:0]     immValue,
	output logic [`ALU_WIDTH-1:0]     errorValue
);
	import aluPkg::*;

	localparam int EXT_WIDTH = `ALU_WIDTH - `ALU_IMM_WIDTH;  // Bits added on extension

	always_comb begin
		op         = OP_NOP;
		immValue   = '0;
		errorValue = '0;
		case (instructionFormat)
			FMT_A: begin
				errorValue = `ERR_FMT_A;
				if (instruction.formatA.opcode[`ALU_OPC_WIDTH-1:0] == `OPC_NOP_LOW) begin
					op = OP_NOP;  // Upper opcode bits ignored
				end else begin
					case (instruction.formatA.opcode)
						`OPC_ADD:  op = OP_ADD;
						`OPC_SUB:  op = OP_SUB;
						`OPC_AND:  op = OP_AND;
						`OPC_OR:   op = OP_OR;
						`OPC_NEG:  op = OP_NEG;
						`OPC_XOR:  op = OP_XOR;
						`OPC_COMP: op = OP_COMP;
						`OPC_LSR:  op = OP_LSR;
						`OPC_ASR:  op = OP_ASR;
						`OPC_LSL:  op = OP_LSL;
						`OPC_ROR:  op = OP_ROR;
						`OPC_ROL:  op = OP_ROL;
						`OPC_MOVE: op = OP_MOVE;
						default:   op = OP_ERR_INR;
					endcase
				end
			end
			FMT_B: begin
				// Only NOP lives in format b
				errorValue = `ERR_FMT_B;
				if (instruction.formatB.opcode == `OPC_NOP_LOW)
					op = OP_NOP;
				else
					op = OP_ERR_INR;
			end
			FMT_C: begin
				errorValue = `ERR_FMT_C;
				case (instruction.formatC.opcode)
					`OPC_NOP_LOW: op = OP_NOP;
					`OPC_LDI: begin
						op       = OP_LDI;
						immValue = {{EXT_WIDTH{instruction.formatC.immediate[`ALU_IMM_WIDTH-1]}},
							instruction.formatC.immediate};  // Sign extend
					end
					`OPC_LDU: begin
						op       = OP_LDU;
						immValue = {{EXT_WIDTH{1'b0}}, instruction.formatC.immediate};
					end
					default: op = OP_ERR_INR;
				endcase
			end
			default: begin
				// Format 3, opcode not looked at
				op         = OP_ERR_IFNR;
				errorValue = `ERR_FORMAT;
			end
		endcase
	end

endmodule

//--- hdl/aluDatapath.sv
// ----------------------------------------------------------------------
// ALU datapath, combinational
// Computes the next rz plus carry, overflow and the flag strobes for
// the decoded operation; rotates pull in the held carry
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluDatapath (
	input  aluPkg::aluOpE             op,
	input  logic [`ALU_WIDTH-1:0]     immValue,
	input  logic [`ALU_WIDTH-1:0]     errorValue,
	input  logic [`ALU_WIDTH-1:0]     ra,
	input  logic [`ALU_WIDTH-1:0]     rb,
	input  logic                      carryFlag,  // Held C from the register
	aluResultIf.source                res
);
	import aluPkg::*;

	localparam int MSB = `ALU_WIDTH - 1;

	logic [MSB:0] sum;
	logic [MSB:0] diff;

	assign sum  = ra + rb;
	assign diff = ra - rb;

	always_comb begin
		// Defaults, no flag writes
		res.result        = '0;
		res.carryOut      = 1'b0;
		res.overflowOut   = 1'b0;
		res.writeCarry    = 1'b0;
		res.writeOverflow = 1'b0;
		res.isNop         = 1'b0;
		res.setInr        = 1'b0;
		res.setIfnr       = 1'b0;
		case (op)
			OP_ADD: begin
				res.result        = sum;
				// Like signs in, other sign out
				res.overflowOut   = (ra[MSB] == rb[MSB]) && (sum[MSB] != ra[MSB]);
				res.writeOverflow = 1'b1;
			end
			OP_SUB: begin
				res.result        = diff;
				res.overflowOut   = (ra[MSB] != rb[MSB]) && (diff[MSB] != ra[MSB]);
				res.writeOverflow = 1'b1;
			end
			OP_AND:  res.result = ra & rb;
			OP_OR:   res.result = ra | rb;
			OP_NEG:  res.result = -ra;   // Two's complement, V untouched
			OP_XOR:  res.result = ra ^ rb;
			OP_COMP: res.result = ~ra;
			OP_LSR: begin
				res.result     = ra >> 1;
				res.carryOut   = ra[0];  // Bit shifted out
				res.writeCarry = 1'b1;
			end
			OP_ASR: begin
				res.result     = $unsigned($signed(ra) >>> 1);  // Sign fill
				res.carryOut   = ra[0];
				res.writeCarry = 1'b1;
			end
			OP_LSL: begin
				res.result     = ra << 1;
				res.carryOut   = ra[MSB];
				res.writeCarry = 1'b1;
			end
			OP_ROR: begin
				res.result     = {carryFlag, ra[MSB:1]};  // 33-bit rotate via C
				res.carryOut   = ra[0];
				res.writeCarry = 1'b1;
			end
			OP_ROL: begin
				res.result     = {ra[MSB-1:0], carryFlag};
				res.carryOut   = ra[MSB];
				res.writeCarry = 1'b1;
			end
			OP_MOVE: res.result = ra;
			OP_LDI, OP_LDU: res.result = immValue;  // Already extended
			OP_ERR_INR: begin
				res.result = errorValue;  // Per-format code
				res.setInr = 1'b1;
			end
			OP_ERR_IFNR: begin
				res.result  = errorValue;
				res.setIfnr = 1'b1;
			end
			default: res.isNop = 1'b1;  // OP_NOP and unused encodings
		endcase
	end

endmodule

//--- hdl/conditionCodeRegister.sv
// ----------------------------------------------------------------------
// Output register for rz and the condition code flags
// NOP holds everything; C and V load only on their write strobes,
// the rest load on every other instruction
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

module conditionCodeRegister (
	input  logic                   clock,
	input  logic                   reset,
	aluResultIf.sink               res,
	output logic [`ALU_WIDTH-1:0]  rz,
	output logic [`ALU_WIDTH-1:0]  ccr,
	output logic                   carryFlag
);
	logic flagC;
	logic flagN;
	logic flagV;
	logic flagZ;
	logic flagInr;
	logic flagIfnr;

	always_ff @(posedge clock) begin
		if (reset) begin
			rz       <= '0;
			flagC    <= 1'b0;
			flagN    <= 1'b0;
			flagV    <= 1'b0;
			flagZ    <= 1'b0;
			flagInr  <= 1'b0;
			flagIfnr <= 1'b0;
		end else if (!res.isNop) begin
			rz    <= res.result;
			flagZ <= (res.result == '0);
			flagN <= res.result[`ALU_WIDTH-1];
			if (res.writeCarry)
				flagC <= res.carryOut;  // Shifts and rotates only
			if (res.writeOverflow)
				flagV <= res.overflowOut;  // ADD and SUB only
			// Error flags follow the current word, good one clears them
			flagInr  <= res.setInr;
			flagIfnr <= res.setIfnr;
		end
	end

	// Pack flags, upper bits stay zero
	always_comb begin
		ccr              = '0;
		ccr[`CCR_C]      = flagC;
		ccr[`CCR_N]      = flagN;
		ccr[`CCR_V]      = flagV;
		ccr[`CCR_Z]      = flagZ;
		ccr[`CCR_INR]    = flagInr;
		ccr[`CCR_IFNR]   = flagIfnr;
	end

	assign carryFlag = flagC;  // Rotate input

endmodule

//--- hdl/arithmeticLogicUnit.sv
// ----------------------------------------------------------------------
// ALU top level, one cycle from inputs to rz and ccr
// Decoder and datapath in front of the output register
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

module arithmeticLogicUnit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [`ALU_WIDTH-1:0]      instruction,
	input  logic [`ALU_FMT_WIDTH-1:0]  instructionFormat,
	input  logic [`ALU_WIDTH-1:0]      ra,
	input  logic [`ALU_WIDTH-1:0]      rb,
	output logic [`ALU_WIDTH-1:0]      rz,
	output logic [`ALU_WIDTH-1:0]      ccr
);
	import aluPkg::*;

	instrFormatE             formatSel;
	aluOpE                   op;
	logic [`ALU_WIDTH-1:0]   immValue;
	logic [`ALU_WIDTH-1:0]   errorValue;
	logic                    carryFlag;  // Held C back to the rotates

	aluResultIf res ();

	assign formatSel = instrFormatE'(instructionFormat);  // All four codes valid

	instructionDecoder decoder (
		.instruction       (instruction),
		.instructionFormat (formatSel),
		.op                (op),
		.immValue          (immValue),
		.errorValue        (errorValue)
	);

	aluDatapath datapath (
		.op         (op),
		.immValue   (immValue),
		.errorValue (errorValue),
		.ra         (ra),
		.rb         (rb),
		.carryFlag  (carryFlag),
		.res        (res.source)
	);

	conditionCodeRegister ccReg (
		.clock     (clock),
		.reset     (reset),
		.res       (res.sink),
		.rz        (rz),
		.ccr       (ccr),
		.carryFlag (carryFlag)
	);

endmodule

//--- sim/aluProps.sv
// ----------------------------------------------------------------------
// Concurrent properties of the ALU top level, attached with bind
// Counts its own assertion failures for the testbench summary
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluProps (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`ALU_WIDTH-1:0]     instruction,
	input  logic [`ALU_FMT_WIDTH-1:0] instructionFormat,
	input  logic [`ALU_WIDTH-1:0]     rz,
	input  logic [`ALU_WIDTH-1:0]     ccr
);
	int failCount = 0;  // Read by the testbench
	logic nopWord;

	// Low six bits all ones, formats a to c
	assign nopWord = (instructionFormat != 2'd3) &&
		(instruction[`ALU_OPC_WIDTH-1:0] == `OPC_NOP_LOW);

	upperCcrZero: assert property (@(posedge clock) disable iff (reset)
		ccr[`ALU_WIDTH-1:`CCR_IFNR+1] == '0)
		else begin
			failCount++;
			$error("ccr bits above IFNR are not zero");
		end

	errorFlagsExclusive: assert property (@(posedge clock) disable iff (reset)
		!(ccr[`CCR_INR] && ccr[`CCR_IFNR]))
		else begin
			failCount++;
			$error("INR and IFNR set together");
		end

	clearAfterReset: assert property (@(posedge clock)
		reset |=> (rz == '0) && (ccr == '0))
		else begin
			failCount++;
			$error("rz or ccr not zero after reset");
		end

	nopHolds: assert property (@(posedge clock) disable iff (reset)
		nopWord |=> $stable(rz) && $stable(ccr))
		else begin
			failCount++;
			$error("NOP changed rz or ccr");
		end

endmodule

bind arithmeticLogicUnit aluProps props (
	.clock             (clock),
	.reset             (reset),
	.instruction       (instruction),
	.instructionFormat (instructionFormat),
	.rz                (rz),
	.ccr               (ccr)
);

//--- sim/aluChecker.sv
// ----------------------------------------------------------------------
// Reference model and scoreboard for the ALU
// Samples the DUT inputs each edge, predicts rz and ccr for the next
// edge and compares them there
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluChecker (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`ALU_WIDTH-1:0]     instruction,
	input  logic [`ALU_FMT_WIDTH-1:0] instructionFormat,
	input  logic [`ALU_WIDTH-1:0]     ra,
	input  logic [`ALU_WIDTH-1:0]     rb,
	input  logic [`ALU_WIDTH-1:0]     rz,
	input  logic [`ALU_WIDTH-1:0]     ccr,
	output int                        errorCount,
	output int                        checkCount
);
	logic [31:0] expRz;  // Model state, one cycle ahead of the DUT
	logic expC;
	logic expN;
	logic expV;
	logic expZ;
	logic expInr;
	logic expIfnr;
	logic expValid;  // Set once a prediction exists

	initial begin
		errorCount = 0;
		checkCount = 0;
		expValid   = 1'b0;
	end

	function automatic logic [31:0] expectedCcr();
		logic [31:0] word;
		word             = '0;
		word[`CCR_C]     = expC;
		word[`CCR_N]     = expN;
		word[`CCR_V]     = expV;
		word[`CCR_Z]     = expZ;
		word[`CCR_INR]   = expInr;
		word[`CCR_IFNR]  = expIfnr;
		return word;
	endfunction

	function automatic int countMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got === want)
			return 0;
		$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
		return 1;
	endfunction

	// One instruction applied to the model
	task automatic predictNext();
		logic [31:0] value;
		logic hold;
		logic inr;
		logic ifnr;
		value = '0;
		hold  = 1'b0;
		inr   = 1'b0;
		ifnr  = 1'b0;
		if (instructionFormat == 2'd3) begin
			ifnr  = 1'b1;  // Opcode ignored
			value = `ERR_FORMAT;
		end else if (instruction[5:0] == 6'h3F) begin
			hold = 1'b1;
		end else if (instructionFormat == 2'd0) begin
			case (instruction[16:0])
				`OPC_ADD: begin
					value = ra + rb;
					expV  = (ra[31] == rb[31]) && (value[31] != ra[31]);
				end
				`OPC_SUB: begin
					value = ra + ~rb + 32'd1;
					expV  = (ra[31] != rb[31]) && (value[31] != ra[31]);
				end
				`OPC_AND:  value = ra & rb;
				`OPC_OR:   value = ra | rb;
				`OPC_NEG:  value = ~ra + 32'd1;
				`OPC_XOR:  value = ra ^ rb;
				`OPC_COMP: value = ~ra;
				`OPC_MOVE: value = ra;
				`OPC_LSR: begin
					value = {1'b0, ra[31:1]};
					expC  = ra[0];
				end
				`OPC_ASR: begin
					value = {ra[31], ra[31:1]};  // Sign kept
					expC  = ra[0];
				end
				`OPC_LSL: begin
					value = {ra[30:0], 1'b0};
					expC  = ra[31];
				end
				`OPC_ROR: begin
					value = {expC, ra[31:1]};  // Old C in at the top
					expC  = ra[0];
				end
				`OPC_ROL: begin
					value = {ra[30:0], expC};
					expC  = ra[31];
				end
				default: begin
					inr   = 1'b1;
					value = `ERR_FMT_A;
				end
			endcase
		end else if (instructionFormat == 2'd2 && instruction[5:0] == `OPC_LDI) begin
			value = {{6{instruction[31]}}, instruction[31:6]};
		end else if (instructionFormat == 2'd2 && instruction[5:0] == `OPC_LDU) begin
			value = {6'b0, instruction[31:6]};
		end else begin
			inr   = 1'b1;  // Format b has only NOP
			value = (instructionFormat == 2'd1) ? `ERR_FMT_B : `ERR_FMT_C;
		end
		if (!hold) begin
			expRz   = value;
			expZ    = (value == 32'h0);
			expN    = value[31];
			expInr  = inr;
			expIfnr = ifnr;
		end
	endtask

	always @(posedge clock) begin : compareStep
		int errs;
		errs = 0;
		if (expValid) begin
			errs += countMismatch("rz", rz, expRz);
			errs += countMismatch("ccr", ccr, expectedCcr());
			checkCount++;
		end
		errorCount += errs;
		if (reset) begin
			expRz   = '0;
			expC    = 1'b0;
			expN    = 1'b0;
			expV    = 1'b0;
			expZ    = 1'b0;
			expInr  = 1'b0;
			expIfnr = 1'b0;
		end else begin
			predictNext();
		end
		expValid = 1'b1;
	end

endmodule

//--- sim/aluTb.sv
// ----------------------------------------------------------------------
// ALU testbench: clock, reset, seeded random instruction stream
// Checker instance compares; summary and verdict printed at the end
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluTb;
	localparam int NUM_CYCLES  = 4000;
	localparam int DRAIN_LIMIT = 10;           // Negedges allowed for the last compares
	localparam int TARGET      = NUM_CYCLES + 3;  // Compares from edge 2 to the end

	logic clock;
	logic reset;
	logic [`ALU_WIDTH-1:0] instruction;
	logic [`ALU_FMT_WIDTH-1:0] instructionFormat;
	logic [`ALU_WIDTH-1:0] ra;
	logic [`ALU_WIDTH-1:0] rb;
	logic [`ALU_WIDTH-1:0] rz;
	logic [`ALU_WIDTH-1:0] ccr;
	int errorCount;
	int checkCount;
	int assertFails;
	int waitCycles;

	arithmeticLogicUnit UUT (
		.clock             (clock),
		.reset             (reset),
		.instruction       (instruction),
		.instructionFormat (instructionFormat),
		.ra                (ra),
		.rb                (rb),
		.rz                (rz),
		.ccr               (ccr)
	);

	aluChecker scoreboard (
		.clock (clock), .reset (reset),
		.instruction (instruction), .instructionFormat (instructionFormat),
		.ra (ra), .rb (rb), .rz (rz), .ccr (ccr),
		.errorCount (errorCount), .checkCount (checkCount)
	);

	always #4 clock = ~clock;  // 8 ns period

	function automatic logic [`ALU_OPA_WIDTH-1:0] pickFormatAOpcode(input int idx);
		case (idx)
			0:       return `OPC_ADD;
			1:       return `OPC_SUB;
			2:       return `OPC_AND;
			3:       return `OPC_OR;
			4:       return `OPC_NEG;
			5:       return `OPC_XOR;
			6:       return `OPC_COMP;
			7:       return `OPC_LSR;
			8:       return `OPC_ASR;
			9:       return `OPC_LSL;
			10:      return `OPC_ROR;
			11:      return `OPC_ROL;
			default: return `OPC_MOVE;
		endcase
	endfunction

	task automatic driveRandomInstruction();
		int kind;
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [1:0] fmt;
		kind = $urandom_range(0, 15);
		word = $urandom;  // Register fields stay random
		a    = $urandom;
		b    = $urandom;
		fmt  = 2'd0;
		if (kind < 6) begin
			word[16:0] = pickFormatAOpcode($urandom_range(0, 12));
		end else if (kind < 9) begin
			fmt       = 2'd2;
			word[5:0] = ($urandom_range(0, 1) == 0) ? `OPC_LDI : `OPC_LDU;
		end else if (kind < 11) begin
			fmt       = 2'($urandom_range(0, 2));  // NOP in a, b or c
			word[5:0] = `OPC_NOP_LOW;
		end else if (kind < 14) begin
			fmt = 2'($urandom_range(0, 2));  // Mostly unrecognized
		end else begin
			fmt = 2'd3;
		end
		case ($urandom_range(0, 7))
			0:       b = a;     // SUB and XOR hit zero
			1:       a = '0;
			default: ;
		endcase
		instruction       <= word;
		instructionFormat <= fmt;
		ra                <= a;
		rb                <= b;
	endtask

	initial begin
		clock             = 1'b0;
		reset             = 1'b1;
		instruction       = '0;
		instructionFormat = '0;
		ra                = '0;
		rb                = '0;
		waitCycles        = 0;
		void'($urandom(32'h9864eacc));
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < NUM_CYCLES; i++) begin
			@(posedge clock);
			driveRandomInstruction();
		end
		// Last inputs still in flight
		while (checkCount < TARGET && waitCycles < DRAIN_LIMIT) begin
			@(negedge clock);
			waitCycles++;
		end
		assertFails = UUT.props.failCount;
		if (checkCount < TARGET) begin
			$display("Timeout: only %0d of %0d compares done", checkCount, TARGET);
			$display("** FAIL **");
		end else begin
			$display("Compares %0d, check errors %0d, assertion failures %0d",
				checkCount, errorCount, assertFails);
			if (errorCount == 0 && assertFails == 0)
				$display("** PASS **");
			else
				$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
hdl/aluPkg.sv
hdl/aluResultIf.sv
hdl/instructionDecoder.sv
hdl/aluDatapath.sv
hdl/conditionCodeRegister.sv
hdl/arithmeticLogicUnit.sv
sim/aluProps.sv
sim/aluChecker.sv
sim/aluTb.sv

//--- Makefile
# Verilator build and run of the ALU testbench

VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINTFLAGS  = --lint-only --timing -Wall
TOP        = aluTb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
RUNFLAGS   = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@grep -qxF '** PASS **' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
